/* rtl/vic_chip_pkg.sv */
`default_nettype none

package vic_chip_pkg;

    // chip strapping, the unused code runs as a 6569
    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0,
        CHIP_6567R56A = 2'd1,
        CHIP_6569     = 2'd2,
        CHIP_UNUSED   = 2'd3
    } chip_t;

    // wrap points and dma windows of one chip
    typedef struct packed {
        logic [9:0] raster_x_max;
        logic [8:0] raster_y_max;
        logic [9:0] max_xpos;
        logic [9:0] xpos_start;
        logic [9:0] chars_ba_start;
        logic [9:0] chars_ba_end;
        logic [9:0] sprite_ba_offset;
    } chip_limits_t;

    localparam int NUM_SPRITES = 8;
    // sprite windows in raster_x pixels
    localparam logic [9:0] SPRITE_BA_STRIDE = 10'd16;
    localparam logic [9:0] SPRITE_BA_LEN = 10'd40;
    // bad lines only happen inside this band
    localparam logic [8:0] BADLINE_FIRST = 9'd48;
    localparam logic [8:0] BADLINE_LAST = 9'd248;

    function automatic chip_limits_t chip_limits(input chip_t chip);
        chip_limits_t lim;
        // common to all three chips
        lim.chars_ba_end = 10'h14c;
        case (chip)
            CHIP_6567R8: begin
                // 520 pixels by 263 lines
                lim.raster_x_max = 10'd519;
                lim.raster_y_max = 9'd262;
                lim.max_xpos = 10'h1ff;
                lim.xpos_start = 10'h19c;
                lim.chars_ba_start = 10'h1f4;
                lim.sprite_ba_offset = 10'h148;
            end
            CHIP_6567R56A: begin
                // 512 pixels by 262 lines
                lim.raster_x_max = 10'd511;
                lim.raster_y_max = 9'd261;
                lim.max_xpos = 10'h1ff;
                lim.xpos_start = 10'h19c;
                lim.chars_ba_start = 10'h1f4;
                lim.sprite_ba_offset = 10'h148;
            end
            default: begin
                // pal part, 504 pixels by 312 lines
                lim.raster_x_max = 10'd503;
                lim.raster_y_max = 9'd311;
                lim.max_xpos = 10'h1f7;
                lim.xpos_start = 10'h194;
                lim.chars_ba_start = 10'h1ec;
                lim.sprite_ba_offset = 10'h140;
            end
        endcase
        return lim;
    endfunction

endpackage

`default_nettype wire

/* rtl/vic_beam_pkg.sv */
`default_nettype none

package vic_beam_pkg;

    // where the beam is, all three change on the same dot
    typedef struct packed {
        logic [9:0] raster_x;
        logic [9:0] xpos;
        logic [8:0] raster_line;
    } beam_pos_t;

    // clock phase strobes derived from the dot4x clock
    typedef struct packed {
        // phi level, low for vic and high for cpu
        logic        phi;
        // one hot, rotates every dot4x tick
        logic [3:0]  dot_rising;
        // one hot tick inside the current phi half, bit 15 is the last
        logic [15:0] phase_start;
    } phase_t;

    // phase_start index for the bad line decision, phi low
    localparam int PH_BADLINE = 1;
    // phase_start index that shifts the ba cascade, phi high
    localparam int PH_CASCADE = 15;
    // dot_rising index on which the counters step
    localparam int DOT_ADVANCE = 0;

endpackage

`default_nettype wire

/* rtl/beam_timing.sv */
`timescale 1ns/100ps
`default_nettype none

module beam_timing (
    input  wire                     clk_dot4x,
    input  wire                     rst,
    input  wire vic_chip_pkg::chip_t chip_i,
    output vic_beam_pkg::beam_pos_t beam_o,
    output vic_beam_pkg::phase_t    phase_o
);

    import vic_chip_pkg::*;
    import vic_beam_pkg::*;

    chip_limits_t lim;

    // dot, phi and half phase rings
    logic [3:0]  dot_ring;
    logic [31:0] phi_ring;
    logic [15:0] start_ring;

    beam_pos_t beam_q;
    logic      advance;
    logic      line_end;
    logic      frame_end;

    assign lim = chip_limits(chip_i);

    // counters step once per pixel
    assign advance = dot_ring[DOT_ADVANCE];
    assign line_end = beam_q.raster_x == lim.raster_x_max;
    assign frame_end = beam_q.raster_line == lim.raster_y_max;

    // reset leaves the dot ring three ticks short of a step so that
    // raster_x stays at 0 for the first four ticks
    // phi ring holds 16 low then 16 high ticks, read out at bit 0
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dot_ring <= 4'b0010;
            phi_ring <= 32'hffff_0000;
            start_ring <= 16'h0001;
        end else begin
            dot_ring <= {dot_ring[2:0], dot_ring[3]};
            phi_ring <= {phi_ring[0], phi_ring[31:1]};
            start_ring <= {start_ring[14:0], start_ring[15]};
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            beam_q.raster_x <= 10'd0;
            beam_q.raster_line <= 9'd0;
            beam_q.xpos <= lim.xpos_start;
        end else if (advance) begin
            if (line_end) begin
                // new line, xpos restarts at the chip's left edge
                beam_q.raster_x <= 10'd0;
                beam_q.xpos <= lim.xpos_start;
                if (frame_end) begin
                    beam_q.raster_line <= 9'd0;
                end else begin
                    beam_q.raster_line <= beam_q.raster_line + 9'd1;
                end
            end else begin
                beam_q.raster_x <= beam_q.raster_x + 10'd1;
                // xpos wraps mid line
                if (beam_q.xpos == lim.max_xpos) begin
                    beam_q.xpos <= 10'd0;
                end else begin
                    beam_q.xpos <= beam_q.xpos + 10'd1;
                end
            end
        end
    end

    assign beam_o = beam_q;

    assign phase_o.phi = phi_ring[0];
    assign phase_o.dot_rising = dot_ring;
    assign phase_o.phase_start = start_ring;

endmodule

`default_nettype wire

/* rtl/char_dma_window.sv */
`timescale 1ns/100ps
`default_nettype none

module char_dma_window (
    input  wire                          clk_dot4x,
    input  wire                          rst,
    input  wire vic_chip_pkg::chip_t     chip_i,
    input  wire vic_beam_pkg::beam_pos_t beam_i,
    input  wire vic_beam_pkg::phase_t    phase_i,
    input  wire                          den_i,
    input  wire [2:0]                    yscroll_i,
    output logic                         ba_chars_o,
    output logic                         badline_o
);

    import vic_chip_pkg::*;
    import vic_beam_pkg::*;

    chip_limits_t lim;

    logic allow_bad_lines;
    logic allow_next;
    logic badline;
    logic eval_strobe;
    logic in_band;
    logic in_xwin;

    assign lim = chip_limits(chip_i);

    // decision made once per phi low half
    assign eval_strobe = ~phase_i.phi & phase_i.phase_start[PH_BADLINE];

    assign in_band = (beam_i.raster_line >= BADLINE_FIRST) &&
                     (beam_i.raster_line < BADLINE_LAST);

    // den only counts on the first line of the band
    always_comb begin
        allow_next = allow_bad_lines;
        if (den_i && beam_i.raster_line == BADLINE_FIRST) begin
            allow_next = 1'b1;
        end
        if (beam_i.raster_line == BADLINE_LAST) begin
            allow_next = 1'b0;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad_lines <= 1'b0;
            badline <= 1'b0;
        end else if (eval_strobe) begin
            allow_bad_lines <= allow_next;
            // uses the flag as updated on this same strobe
            badline <= (beam_i.raster_line[2:0] == yscroll_i) && allow_next && in_band;
        end
    end

    // c-access window wraps through xpos 0
    assign in_xwin = (beam_i.xpos >= lim.chars_ba_start) ||
                     (beam_i.xpos < lim.chars_ba_end);

    // ba pulled low for the whole fetch window of a bad line
    assign ba_chars_o = ~(badline & in_xwin);
    assign badline_o = badline;

endmodule

`default_nettype wire

/* rtl/sprite_dma_window.sv */
`timescale 1ns/100ps
`default_nettype none

module sprite_dma_window (
    input  wire vic_chip_pkg::chip_t            chip_i,
    input  wire vic_beam_pkg::beam_pos_t        beam_i,
    input  wire [vic_chip_pkg::NUM_SPRITES-1:0] sprite_dma_i,
    output logic [vic_chip_pkg::NUM_SPRITES-1:0] ba_sprite_o
);

    import vic_chip_pkg::*;

    chip_limits_t lim;

    logic [9:0] line_len;
    // raster_x moved so sprite 0's ba fall sits at 0
    logic [9:0] sprite_raster_x;

    assign lim = chip_limits(chip_i);
    assign line_len = lim.raster_x_max + 10'd1;

    // modulo the line length, keeps every window free of wrap
    assign sprite_raster_x = (beam_i.raster_x >= lim.sprite_ba_offset) ?
                             beam_i.raster_x - lim.sprite_ba_offset :
                             beam_i.raster_x + line_len - lim.sprite_ba_offset;

    // one window per sprite, stride apart
    always_comb begin
        for (int n = 0; n < NUM_SPRITES; n++) begin
            ba_sprite_o[n] = sprite_dma_i[n] &&
                             (sprite_raster_x >= 10'(n) * SPRITE_BA_STRIDE) &&
                             (sprite_raster_x < 10'(n) * SPRITE_BA_STRIDE + SPRITE_BA_LEN);
        end
    end

endmodule

`default_nettype wire

/* rtl/bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
    input  wire                                 clk_dot4x,
    input  wire                                 rst,
    input  wire vic_beam_pkg::phase_t           phase_i,
    input  wire                                 ba_chars_i,
    input  wire [vic_chip_pkg::NUM_SPRITES-1:0] ba_sprite_i,
    output logic                                ba_o,
    output logic                                aec_o
);

    import vic_beam_pkg::*;

    // stage 2 is the one that gates aec
    logic [2:0] cascade;
    logic       cascade_strobe;

    // last tick of each phi high half
    assign cascade_strobe = phase_i.phi & phase_i.phase_start[PH_CASCADE];

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_o <= 1'b0;
            aec_o <= 1'b0;
            cascade <= 3'b000;
        end else begin
            // any dma request pulls ba low
            ba_o <= ba_chars_i & ~|ba_sprite_i;
            // a low ba takes three phi high halves to reach stage 2
            if (cascade_strobe) begin
                cascade[0] <= ba_o;
                cascade[1] <= cascade[0] | ba_o;
                cascade[2] <= cascade[1] | ba_o;
            end
            // cpu keeps phi high slots until the cascade runs out
            aec_o <= ba_o ? phase_i.phi : cascade[2] & phase_i.phi;
        end
    end

endmodule

`default_nettype wire

/* rtl/vic_bus_timing.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_bus_timing (
    input  wire                      clk_dot4x,
    input  wire                      rst,
    input  wire vic_chip_pkg::chip_t chip_i,
    input  wire                      den_i,
    input  wire [2:0]                yscroll_i,
    input  wire [7:0]                sprite_dma_i,
    output logic                     clk_phi_o,
    output logic [9:0]               raster_x_o,
    output logic [9:0]               xpos_o,
    output logic [8:0]               raster_line_o,
    output logic                     badline_o,
    output logic                     ba_o,
    output logic                     aec_o
);

    import vic_beam_pkg::*;

    beam_pos_t  beam;
    phase_t     phase;
    logic       ba_chars;
    logic [7:0] ba_sprite;

    // beam position and phase strobes feed both windows
    beam_timing beam_timing_i (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip_i    (chip_i),
        .beam_o    (beam),
        .phase_o   (phase)
    );

    char_dma_window char_dma_window_i (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .chip_i     (chip_i),
        .beam_i     (beam),
        .phase_i    (phase),
        .den_i      (den_i),
        .yscroll_i  (yscroll_i),
        .ba_chars_o (ba_chars),
        .badline_o  (badline_o)
    );

    sprite_dma_window sprite_dma_window_i (
        .chip_i       (chip_i),
        .beam_i       (beam),
        .sprite_dma_i (sprite_dma_i),
        .ba_sprite_o  (ba_sprite)
    );

    bus_arbiter bus_arbiter_i (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .phase_i     (phase),
        .ba_chars_i  (ba_chars),
        .ba_sprite_i (ba_sprite),
        .ba_o        (ba_o),
        .aec_o       (aec_o)
    );

    assign clk_phi_o = phase.phi;
    assign raster_x_o = beam.raster_x;
    assign xpos_o = beam.xpos;
    assign raster_line_o = beam.raster_line;

endmodule

`default_nettype wire

/* bench/tb_vic_bus_timing.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_vic_bus_timing;

    import vic_chip_pkg::*;
    import vic_beam_pkg::*;

    logic       clk_dot4x;
    logic       rst;
    chip_t      chip_i;
    logic       den_i;
    logic [2:0] yscroll_i;
    logic [7:0] sprite_dma_i;
    logic       clk_phi_o;
    logic [9:0] raster_x_o;
    logic [9:0] xpos_o;
    logic [8:0] raster_line_o;
    logic       badline_o;
    logic       ba_o;
    logic       aec_o;

    // reference model state
    beam_pos_t  m_beam;
    logic [1:0] m_dot;
    logic [4:0] m_tick;
    logic       m_allow;
    logic       m_badline;
    logic       m_ba;
    logic [2:0] m_cascade;
    logic       m_aec;

    string  test_name;
    integer seed;
    int     cycles = 0;
    int     cycle_limit;
    int     badline_ticks = 0;
    logic   phi_prev;

    vic_bus_timing dut_i (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .chip_i        (chip_i),
        .den_i         (den_i),
        .yscroll_i     (yscroll_i),
        .sprite_dma_i  (sprite_dma_i),
        .clk_phi_o     (clk_phi_o),
        .raster_x_o    (raster_x_o),
        .xpos_o        (xpos_o),
        .raster_line_o (raster_line_o),
        .badline_o     (badline_o),
        .ba_o          (ba_o),
        .aec_o         (aec_o)
    );

    // 20 ns dot4x clock
    initial begin
        clk_dot4x = 1'b0;
        forever #10 clk_dot4x = ~clk_dot4x;
    end

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("Mismatch in %s: %s expected %0d actual %0d", test_name, what, expected, actual);
        $display("Simulation failed");
        $fatal(1, "value check failed");
    endtask

    task automatic report_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    // limits of the three parts with CHIP_UNUSED running as 6569
    function automatic chip_limits_t ref_limits(input chip_t chip);
        chip_limits_t l;
        l.chars_ba_end = 10'h14c;
        if (chip == CHIP_6567R8 || chip == CHIP_6567R56A) begin
            l.raster_x_max = (chip == CHIP_6567R8) ? 10'd519 : 10'd511;
            l.raster_y_max = (chip == CHIP_6567R8) ? 9'd262 : 9'd261;
            l.max_xpos = 10'h1ff;
            l.xpos_start = 10'h19c;
            l.chars_ba_start = 10'h1f4;
            l.sprite_ba_offset = 10'h148;
        end else begin
            l.raster_x_max = 10'd503;
            l.raster_y_max = 9'd311;
            l.max_xpos = 10'h1f7;
            l.xpos_start = 10'h194;
            l.chars_ba_start = 10'h1ec;
            l.sprite_ba_offset = 10'h140;
        end
        return l;
    endfunction

    // one pixel step of the beam
    function automatic beam_pos_t next_beam(input beam_pos_t b, input chip_limits_t l);
        beam_pos_t n;
        n = b;
        if (b.raster_x == l.raster_x_max) begin
            n.raster_x = 10'd0;
            n.xpos = l.xpos_start;
            n.raster_line = (b.raster_line == l.raster_y_max) ? 9'd0 : b.raster_line + 9'd1;
        end else begin
            n.raster_x = b.raster_x + 10'd1;
            n.xpos = (b.xpos == l.max_xpos) ? 10'd0 : b.xpos + 10'd1;
        end
        return n;
    endfunction

    // clear on line 248 wins over a set on line 48
    function automatic logic next_allow(input logic allow, input logic den,
                                        input logic [8:0] line);
        if (line == BADLINE_LAST) begin
            return 1'b0;
        end
        if (den && line == BADLINE_FIRST) begin
            return 1'b1;
        end
        return allow;
    endfunction

    function automatic logic eval_badline(input logic [8:0] line, input logic [2:0] ysc,
                                          input logic allow);
        return (line[2:0] == ysc) && allow && line >= 9'd48 && line < 9'd248;
    endfunction

    // high when no character fetch needs the bus
    function automatic logic char_ba(input logic badline, input logic [9:0] xpos,
                                     input chip_limits_t l);
        return !(badline && (xpos >= l.chars_ba_start || xpos < l.chars_ba_end));
    endfunction

    function automatic logic [NUM_SPRITES-1:0] sprite_windows(input logic [9:0] raster_x,
                                                              input logic [7:0] dma,
                                                              input chip_limits_t l);
        logic [NUM_SPRITES-1:0] hits;
        int len;
        int pos;
        len = int'(l.raster_x_max) + 1;
        pos = (int'(raster_x) - int'(l.sprite_ba_offset) + len) % len;
        // windows 16 pixels apart and 40 pixels long
        for (int n = 0; n < NUM_SPRITES; n++) begin
            hits[n] = dma[n] && pos >= 16 * n && pos < 16 * n + 40;
        end
        return hits;
    endfunction

    function automatic logic [2:0] shift_cascade(input logic [2:0] c, input logic ba);
        return {c[1] | ba, c[0] | ba, ba};
    endfunction

    function automatic logic next_aec(input logic ba, input logic c2, input logic phi);
        return ba ? phi : (c2 && phi);
    endfunction

    // two frames per chip plus margin
    function automatic int timeout_limit();
        int total;
        chip_limits_t l;
        total = 100;
        for (int c = 0; c < 3; c++) begin
            l = ref_limits(chip_t'(c));
            total += 2 * (int'(l.raster_x_max) + 1) * (int'(l.raster_y_max) + 1) * 4;
        end
        return total;
    endfunction

    // reference model stepping on the same edge as the DUT
    always @(posedge clk_dot4x) begin : model
        chip_limits_t lim;
        logic         phi;
        logic         allow_n;
        lim = ref_limits(chip_i);
        phi = m_tick[4];
        if (rst) begin
            m_beam.raster_x <= 10'd0;
            m_beam.xpos <= lim.xpos_start;
            m_beam.raster_line <= 9'd0;
            m_dot <= 2'd0;
            m_tick <= 5'd0;
            m_allow <= 1'b0;
            m_badline <= 1'b0;
            m_ba <= 1'b0;
            m_cascade <= 3'b000;
            m_aec <= 1'b0;
        end else begin
            // fourth tick moves the beam
            m_dot <= m_dot + 2'd1;
            if (m_dot == 2'd3) begin
                m_beam <= next_beam(m_beam, lim);
            end
            m_tick <= m_tick + 5'd1;
            if (!phi && m_tick[3:0] == 4'(PH_BADLINE)) begin
                allow_n = next_allow(m_allow, den_i, m_beam.raster_line);
                m_allow <= allow_n;
                m_badline <= eval_badline(m_beam.raster_line, yscroll_i, allow_n);
            end
            m_ba <= char_ba(m_badline, m_beam.xpos, lim) &&
                    (sprite_windows(m_beam.raster_x, sprite_dma_i, lim) == '0);
            // last tick of phi high
            if (phi && m_tick[3:0] == 4'(PH_CASCADE)) begin
                m_cascade <= shift_cascade(m_cascade, m_ba);
            end
            m_aec <= next_aec(m_ba, m_cascade[2], phi);
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk_dot4x) begin : compare
        if (!rst) begin
            assert (clk_phi_o == raster_x_o[2])
                else report_error("clk_phi_o does not follow raster_x bit 2");
            assert (raster_x_o == m_beam.raster_x)
                else report_mismatch("raster_x", int'(m_beam.raster_x), int'(raster_x_o));
            assert (xpos_o == m_beam.xpos)
                else report_mismatch("xpos", int'(m_beam.xpos), int'(xpos_o));
            assert (raster_line_o == m_beam.raster_line)
                else report_mismatch("raster_line", int'(m_beam.raster_line),
                                     int'(raster_line_o));
            assert (clk_phi_o == m_tick[4])
                else report_mismatch("clk_phi", int'(m_tick[4]), int'(clk_phi_o));
            assert (badline_o == m_badline)
                else report_mismatch("badline", int'(m_badline), int'(badline_o));
            assert (ba_o == m_ba)
                else report_mismatch("ba", int'(m_ba), int'(ba_o));
            // aec lags phi by one tick
            assert (!(aec_o && !clk_phi_o && !phi_prev))
                else report_error("aec_o is high inside the phi low half");
            assert (aec_o == m_aec)
                else report_mismatch("aec", int'(m_aec), int'(aec_o));
            if (badline_o) begin
                badline_ticks++;
            end
        end
        phi_prev = clk_phi_o;
    end

    always @(posedge clk_dot4x) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            report_error("the run did not finish within the cycle limit");
        end
    end

    // den high in the first frame while sprites run random on odd lines and in the second frame
    task automatic drive_line(input logic second_frame, input logic odd_line);
        yscroll_i <= 3'($random(seed));
        den_i <= ~second_frame;
        if (second_frame || odd_line) begin
            sprite_dma_i <= 8'($random(seed));
        end else begin
            sprite_dma_i <= 8'd0;
        end
    endtask

    task automatic run_chip(input chip_t chip, input string name);
        chip_limits_t lim;
        int           lines;
        int           bad_before;
        logic [8:0]   cur_line;
        lim = ref_limits(chip);
        lines = 2 * (int'(lim.raster_y_max) + 1);
        @(posedge clk_dot4x);
        test_name = name;
        rst <= 1'b1;
        chip_i <= chip;
        repeat (3) @(posedge clk_dot4x);
        rst <= 1'b0;
        bad_before = badline_ticks;
        for (int l = 0; l < lines; l++) begin
            drive_line(l >= lines / 2, (l % 2) == 1);
            cur_line = raster_line_o;
            do begin
                @(posedge clk_dot4x);
            end while (raster_line_o == cur_line);
        end
        assert (badline_ticks > bad_before)
            else report_error("no bad line was seen in the den high frame");
    endtask

    initial begin : stimulus
        seed = 32'h1d83_e283;
        cycle_limit = timeout_limit();
        test_name = "reset";
        rst <= 1'b1;
        chip_i <= CHIP_6567R8;
        den_i <= 1'b0;
        yscroll_i <= 3'd0;
        sprite_dma_i <= 8'd0;
        run_chip(CHIP_6567R8, "6567R8");
        run_chip(CHIP_6567R56A, "6567R56A");
        run_chip(CHIP_6569, "6569");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
rtl/vic_chip_pkg.sv
rtl/vic_beam_pkg.sv
rtl/beam_timing.sv
rtl/char_dma_window.sv
rtl/sprite_dma_window.sv
rtl/bus_arbiter.sv
rtl/vic_bus_timing.sv
bench/tb_vic_bus_timing.sv

/* Makefile */
# Verilator build and run of the bus timing testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_vic_bus_timing -Mdir obj_dir -o vsim -f all.f
	./obj_dir/vsim 2>&1 | tee sim.log
	@grep -q "Simulation completed successfully" sim.log && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir sim.log
